//--- Makefile
# Verilator build and run for the pipelined MIPS core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
LOG       ?= sim.log
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a failed check or an aborted run fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- rtl/decode_unit.sv
`timescale 1ns/100ps

module decode_unit (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::if_id_t    if_id,
    input  logic                mem_busy,
    input  mips_pkg::reg_addr_t ex_load_dest,
    input  logic                ex_load,
    input  mips_pkg::word_t     rs_data,
    input  mips_pkg::word_t     rt_data,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output logic                load_stall,
    output mips_pkg::id_ex_t    id_ex
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rd;
    logic [15:0] imm;
    word_t       imm_ext;
    alu_op_e     alu_op;
    reg_addr_t   dest;
    logic        known;
    logic        writes_reg;
    logic        use_imm;
    logic        uses_rs;
    logic        uses_rt;
    logic        is_load;
    logic        is_store;
    logic        issue;

    // instruction fields
    assign opcode = if_id.instr[31:26];
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign rd     = if_id.instr[15:11];
    assign imm    = if_id.instr[15:0];
    assign funct  = if_id.instr[5:0];

    // lui shifts its immediate, everything else sign-extends
    assign imm_ext = (opcode == op_lui) ? {imm, 16'h0000} : {{16{imm[15]}}, imm};

    always_comb begin
        alu_op     = alu_add;
        dest       = rt;
        known      = 1'b1;
        writes_reg = 1'b1;
        use_imm    = 1'b1;
        uses_rs    = 1'b0;
        uses_rt    = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        case (opcode)
            op_special: begin
                dest    = rd;
                use_imm = 1'b0;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    // nop lands here too
                    default: begin
                        known   = 1'b0;
                        uses_rs = 1'b0;
                        uses_rt = 1'b0;
                    end
                endcase
            end
            op_addiu: uses_rs = 1'b1;
            op_lui:   alu_op = alu_lui;
            op_lw: begin
                uses_rs = 1'b1;
                is_load = 1'b1;
            end
            op_sw: begin
                uses_rs    = 1'b1;
                uses_rt    = 1'b1;
                is_store   = 1'b1;
                writes_reg = 1'b0;
            end
            default: known = 1'b0;
        endcase
    end

    // load in EX feeding a source read here
    assign load_stall = if_id.valid && ex_load
        && ((uses_rs && rs == ex_load_dest) || (uses_rt && rt == ex_load_dest));

    assign issue = if_id.valid && !load_stall;

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            id_ex.valid     <= issue;
            id_ex.pc        <= if_id.pc;
            id_ex.alu_op    <= alu_op;
            id_ex.rs        <= rs;
            id_ex.rt        <= rt;
            id_ex.rs_data   <= rs_data;
            id_ex.rt_data   <= rt_data;
            id_ex.use_imm   <= use_imm;
            id_ex.imm       <= imm_ext;
            id_ex.dest      <= dest;
            id_ex.rf_wen    <= issue && known && writes_reg && dest != '0;
            id_ex.mem_read  <= issue && known && is_load;
            id_ex.mem_write <= issue && known && is_store;
        end
        if (reset) begin
            id_ex.valid     <= 1'b0;
            id_ex.rf_wen    <= 1'b0;
            id_ex.mem_read  <= 1'b0;
            id_ex.mem_write <= 1'b0;
        end
    end

endmodule

//--- rtl/execute_unit.sv
`timescale 1ns/100ps

module execute_unit (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::id_ex_t    id_ex,
    input  logic                mem_busy,
    input  mips_pkg::me_wb_t    me_wb,
    output mips_pkg::ex_me_t    ex_me,
    output mips_pkg::reg_addr_t ex_load_dest,
    output logic                ex_load
);
    import mips_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t op_a_q;
    word_t op_b_q;
    logic  held;
    word_t alu_b;
    word_t alu_res;

    // newest producer wins, ME before WB
    function automatic word_t forward(reg_addr_t src, word_t base, ex_me_t me, me_wb_t wb);
        if (src != '0 && me.rf_wen && me.dest == src) begin
            return me.alu_res;
        end
        if (src != '0 && wb.rf_wen && wb.dest == src) begin
            return wb.data;
        end
        return base;
    endfunction

    // operands seen while stalled, since WB moves on under a held EX
    always_ff @(posedge clk) begin
        if (mem_busy) begin
            op_a_q <= op_a;
            op_b_q <= op_b;
        end
        held <= mem_busy;
        if (reset) begin
            held <= 1'b0;
        end
    end

    assign op_a  = forward(id_ex.rs, held ? op_a_q : id_ex.rs_data, ex_me, me_wb);
    assign op_b  = forward(id_ex.rt, held ? op_b_q : id_ex.rt_data, ex_me, me_wb);
    assign alu_b = id_ex.use_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            alu_add: alu_res = op_a + alu_b;
            alu_sub: alu_res = op_a - alu_b;
            alu_and: alu_res = op_a & alu_b;
            alu_or:  alu_res = op_a | alu_b;
            alu_slt: alu_res = {31'b0, $signed(op_a) < $signed(alu_b)};
            alu_lui: alu_res = alu_b;
            default: alu_res = '0;
        endcase
    end

    // load facts for the hazard check in decode
    assign ex_load_dest = id_ex.dest;
    assign ex_load      = id_ex.valid && id_ex.mem_read && id_ex.rf_wen;

    ////////////////////////////////////////////////////////////
    // EX/ME register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!mem_busy) begin
            ex_me.valid      <= id_ex.valid;
            ex_me.pc         <= id_ex.pc;
            ex_me.alu_res    <= alu_res;
            ex_me.store_data <= op_b;
            ex_me.dest       <= id_ex.dest;
            ex_me.rf_wen     <= id_ex.rf_wen;
            ex_me.mem_read   <= id_ex.mem_read;
            ex_me.mem_write  <= id_ex.mem_write;
        end
        if (reset) begin
            ex_me.valid     <= 1'b0;
            ex_me.rf_wen    <= 1'b0;
            ex_me.mem_read  <= 1'b0;
            ex_me.mem_write <= 1'b0;
        end
    end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
    parameter mips_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic              clk,
    input  logic              reset,
    input  mips_pkg::wb_rsp_t i_rsp,
    input  logic              mem_busy,
    input  logic              load_stall,
    output mips_pkg::wb_req_t i_req,
    output mips_pkg::if_id_t  if_id
);
    import mips_pkg::*;

    bus_state_e state;
    word_t      pc;
    logic       slot_valid;
    word_t      slot_instr;
    logic       hold;
    logic       ack_now;

    assign hold    = mem_busy | load_stall;
    assign ack_now = (state == bus_wait_ack) && i_rsp.ack;

    // one fetch at a time, none while a fetched word still waits
    always_ff @(posedge clk) begin
        case (state)
            bus_idle: begin
                if (!slot_valid) begin
                    i_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: pc, dat: '0, sel: 4'hf};
                    state <= bus_wait_ack;
                end
            end
            bus_wait_ack: begin
                if (i_rsp.ack) begin
                    i_req.cyc <= 1'b0;
                    i_req.stb <= 1'b0;
                    state     <= bus_idle;
                end
            end
            default: state <= bus_idle;
        endcase
        if (reset) begin
            state     <= bus_idle;
            i_req.cyc <= 1'b0;
            i_req.stb <= 1'b0;
        end
    end

    // pc points at the word in flight or parked in the slot
    always_ff @(posedge clk) begin
        if (ack_now && hold) begin
            slot_valid <= 1'b1;
            slot_instr <= i_rsp.dat;
        end
        if (!hold) begin
            if_id.valid <= slot_valid | ack_now;
            if_id.pc    <= pc;
            if_id.instr <= slot_valid ? slot_instr : i_rsp.dat;
            if (slot_valid || ack_now) begin
                pc <= pc + 32'd4;
            end
            slot_valid <= 1'b0;
        end
        if (reset) begin
            slot_valid  <= 1'b0;
            if_id.valid <= 1'b0;
            pc          <= reset_pc;
        end
    end

endmodule

//--- rtl/mem_unit.sv
`timescale 1ns/100ps

module mem_unit (
    input  logic              clk,
    input  logic              reset,
    input  mips_pkg::ex_me_t  ex_me,
    input  mips_pkg::wb_rsp_t d_rsp,
    output mips_pkg::wb_req_t d_req,
    output logic              mem_busy,
    output mips_pkg::me_wb_t  me_wb
);
    import mips_pkg::*;

    bus_state_e state;
    logic       mem_op;
    logic       ack_now;
    logic       done;

    assign mem_op   = ex_me.valid && (ex_me.mem_read || ex_me.mem_write);
    assign ack_now  = (state == bus_wait_ack) && d_rsp.ack;
    assign mem_busy = mem_op && !ack_now;
    assign done     = !mem_op || ack_now;

    // word access only, all byte lanes
    always_ff @(posedge clk) begin
        case (state)
            bus_idle: begin
                if (mem_op) begin
                    d_req <= '{cyc: 1'b1, stb: 1'b1, we: ex_me.mem_write,
                               adr: ex_me.alu_res, dat: ex_me.store_data, sel: 4'hf};
                    state <= bus_wait_ack;
                end
            end
            bus_wait_ack: begin
                if (d_rsp.ack) begin
                    d_req.cyc <= 1'b0;
                    d_req.stb <= 1'b0;
                    state     <= bus_idle;
                end
            end
            default: state <= bus_idle;
        endcase
        if (reset) begin
            state     <= bus_idle;
            d_req.cyc <= 1'b0;
            d_req.stb <= 1'b0;
        end
    end

    // bubble into WB until the access completes
    always_ff @(posedge clk) begin
        me_wb.valid  <= ex_me.valid && done;
        me_wb.rf_wen <= ex_me.rf_wen && done;
        me_wb.pc     <= ex_me.pc;
        me_wb.dest   <= ex_me.dest;
        me_wb.data   <= ex_me.mem_read ? d_rsp.dat : ex_me.alu_res;
        if (reset) begin
            me_wb.valid  <= 1'b0;
            me_wb.rf_wen <= 1'b0;
        end
    end

endmodule

//--- rtl/mips_core.sv
`timescale 1ns/100ps

module mips_core #(
    parameter mips_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::wb_rsp_t   i_rsp,
    input  mips_pkg::wb_rsp_t   d_rsp,
    output mips_pkg::wb_req_t   i_req,
    output mips_pkg::wb_req_t   d_req,
    output mips_pkg::word_t     debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output mips_pkg::reg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t     debug_wb_rf_wdata
);
    import mips_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_me_t    ex_me;
    me_wb_t    me_wb;
    logic      mem_busy;
    logic      load_stall;
    reg_addr_t rs;
    reg_addr_t rt;
    word_t     rs_data;
    word_t     rt_data;
    reg_addr_t ex_load_dest;
    logic      ex_load;
    logic      trace_on;

    ////////////////////////////////////////////////////////////
    // pipeline stages
    ////////////////////////////////////////////////////////////
    fetch_unit #(.reset_pc(reset_pc)) u_fetch (
        .clk(clk), .reset(reset), .i_rsp(i_rsp), .mem_busy(mem_busy),
        .load_stall(load_stall), .i_req(i_req), .if_id(if_id)
    );

    decode_unit u_decode (
        .clk(clk), .reset(reset), .if_id(if_id), .mem_busy(mem_busy),
        .ex_load_dest(ex_load_dest), .ex_load(ex_load),
        .rs_data(rs_data), .rt_data(rt_data),
        .rs(rs), .rt(rt), .load_stall(load_stall), .id_ex(id_ex)
    );

    // write port straight from the ME/WB register
    reg_file u_regs (
        .clk(clk), .reset(reset), .rs(rs), .rt(rt),
        .wen(me_wb.rf_wen), .waddr(me_wb.dest), .wdata(me_wb.data),
        .rs_data(rs_data), .rt_data(rt_data)
    );

    execute_unit u_execute (
        .clk(clk), .reset(reset), .id_ex(id_ex), .mem_busy(mem_busy), .me_wb(me_wb),
        .ex_me(ex_me), .ex_load_dest(ex_load_dest), .ex_load(ex_load)
    );

    mem_unit u_mem (
        .clk(clk), .reset(reset), .ex_me(ex_me), .d_rsp(d_rsp),
        .d_req(d_req), .mem_busy(mem_busy), .me_wb(me_wb)
    );

    // debug trace, zeroed when nothing is written back
    assign trace_on          = me_wb.valid && me_wb.rf_wen;
    assign debug_wb_pc       = trace_on ? me_wb.pc : '0;
    assign debug_wb_rf_wen   = trace_on ? trace_wen_on : 4'h0;
    assign debug_wb_rf_wnum  = trace_on ? me_wb.dest : '0;
    assign debug_wb_rf_wdata = trace_on ? me_wb.data : '0;

endmodule

//--- rtl/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    ////////////////////////////////////////////////////////////
    // instruction encodings
    ////////////////////////////////////////////////////////////
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct field, special opcode only
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;

    // trace write enable, one bit per byte lane
    localparam logic [3:0] trace_wen_on = 4'hf;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui
    } alu_op_e;

    typedef enum logic {
        bus_idle,
        bus_wait_ack
    } bus_state_e;

    ////////////////////////////////////////////////////////////
    // wishbone classic
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        word_t      adr;
        word_t      dat;
        logic [3:0] sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    ////////////////////////////////////////////////////////////
    // pipeline registers
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        reg_addr_t rs;
        reg_addr_t rt;
        word_t     rs_data;
        word_t     rt_data;
        logic      use_imm;
        word_t     imm;
        reg_addr_t dest;
        logic      rf_wen;
        logic      mem_read;
        logic      mem_write;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     alu_res;
        word_t     store_data;
        reg_addr_t dest;
        logic      rf_wen;
        logic      mem_read;
        logic      mem_write;
    } ex_me_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t dest;
        logic      rf_wen;
        word_t     data;
    } me_wb_t;

endpackage

//--- rtl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  mips_pkg::reg_addr_t rs,
    input  mips_pkg::reg_addr_t rt,
    input  logic                wen,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data
);
    import mips_pkg::*;

    // $0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && !reset && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // write-back in the same cycle is visible to decode
    assign rs_data = (rs == '0) ? '0 : (wen && waddr == rs) ? wdata : regs[rs];
    assign rt_data = (rt == '0) ? '0 : (wen && waddr == rt) ? wdata : regs[rt];

endmodule

//--- tb.f
rtl/mips_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/mem_unit.sv
rtl/mips_core.sv
tests/tb_clock.sv
tests/core_assertions.sv
tests/tb_top.sv

//--- tests/core_assertions.sv
`timescale 1ns/100ps

module core_assertions (
    input logic                clk,
    input logic                reset,
    input mips_pkg::wb_req_t   i_req,
    input mips_pkg::wb_rsp_t   i_rsp,
    input mips_pkg::wb_req_t   d_req,
    input mips_pkg::wb_rsp_t   d_rsp,
    input mips_pkg::word_t     debug_wb_pc,
    input logic [3:0]          debug_wb_rf_wen,
    input mips_pkg::reg_addr_t debug_wb_rf_wnum,
    input mips_pkg::word_t     debug_wb_rf_wdata
);

    ////////////////////////////////////////////////////////////
    // wishbone classic master rules
    ////////////////////////////////////////////////////////////
    i_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        i_req.stb |-> i_req.cyc)
        else $error("instruction port raised stb without cyc");

    d_stb_in_cyc: assert property (@(posedge clk) disable iff (reset)
        d_req.stb |-> d_req.cyc)
        else $error("data port raised stb without cyc");

    // address held until the ack is sampled
    i_adr_held: assert property (@(posedge clk) disable iff (reset)
        (i_req.cyc && !i_rsp.ack) |=> (i_req.cyc && $stable(i_req.adr)))
        else $error("instruction address changed before ack");

    d_adr_held: assert property (@(posedge clk) disable iff (reset)
        (d_req.cyc && !d_rsp.ack) |=> (d_req.cyc && $stable(d_req.adr)))
        else $error("data address changed before ack");

    // trace fields are quiet without a register write
    trace_quiet: assert property (@(posedge clk) disable iff (reset)
        (debug_wb_rf_wen == 4'h0) |->
            (debug_wb_pc == '0 && debug_wb_rf_wnum == '0 && debug_wb_rf_wdata == '0))
        else $error("trace fields not zero while the write enable is low");

endmodule

bind mips_core core_assertions u_assertions (
    .clk(clk), .reset(reset), .i_req(i_req), .i_rsp(i_rsp),
    .d_req(d_req), .d_rsp(d_rsp), .debug_wb_pc(debug_wb_pc),
    .debug_wb_rf_wen(debug_wb_rf_wen), .debug_wb_rf_wnum(debug_wb_rf_wnum),
    .debug_wb_rf_wdata(debug_wb_rf_wdata)
);

//--- tests/core_testdata.hex
// program: word count, then the instruction words, five per line
// trace: entry count, then one entry per line as pc, register, write data
// stores: entry count, then one entry per line as address, write data
00000019
3c011234 24020005 2403fffd 00432021 00822823
00a2302a 00233824 00e24025 24400007 00000000
24090040 ad280000 8d2a0000 01425821 ad2b0004
8d2c0004 018b6823 0060702a 25cf7fff ac0f0008
8c100008 02100025 020f8821 3c12ffff 0251982a
00000013
bfc00000 00000001 12340000
bfc00004 00000002 00000005
bfc00008 00000003 fffffffd
bfc0000c 00000004 00000002
bfc00010 00000005 fffffffd
bfc00014 00000006 00000001
bfc00018 00000007 12340000
bfc0001c 00000008 12340005
bfc00028 00000009 00000040
bfc00030 0000000a 12340005
bfc00034 0000000b 1234000a
bfc0003c 0000000c 1234000a
bfc00040 0000000d 00000000
bfc00044 0000000e 00000001
bfc00048 0000000f 00008000
bfc00050 00000010 00008000
bfc00058 00000011 00010000
bfc0005c 00000012 ffff0000
bfc00060 00000013 00000001
00000003
00000040 12340005
00000044 1234000a
00000008 00008000

//--- tests/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/100ps

module tb_top;
    import mips_pkg::*;

    localparam word_t reset_pc  = 32'hbfc0_0000;
    localparam int    max_words = 64;

    logic       clk;
    logic       reset;
    wb_req_t    i_req;
    wb_rsp_t    i_rsp;
    wb_req_t    d_req;
    wb_rsp_t    d_rsp;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    // program and expected results as read from the data file
    word_t testdata  [0:255];
    word_t prog      [0:max_words-1];
    word_t exp_pc    [0:max_words-1];
    word_t exp_reg   [0:max_words-1];
    word_t exp_data  [0:max_words-1];
    word_t exp_addr  [0:max_words-1];
    word_t exp_store [0:max_words-1];
    word_t dmem      [0:63];

    int    prog_len;
    int    trace_len;
    int    store_len;
    int    trace_seen;
    int    store_seen;
    int    error_count;
    int    tests_passed;
    int    tests_failed;
    int    cycle_count;
    int    cycle_limit;
    int    i_wait;
    int    d_wait;
    logic  i_started;
    logic  d_started;
    logic  fetch_seen;
    logic  early_activity;
    word_t first_adr;

    tb_clock #(.period_ns(40), .reset_cycles(3)) u_clock (.clk(clk), .reset(reset));

    mips_core #(.reset_pc(reset_pc)) u_dut (
        .clk(clk), .reset(reset), .i_rsp(i_rsp), .d_rsp(d_rsp),
        .i_req(i_req), .d_req(d_req), .debug_wb_pc(debug_wb_pc),
        .debug_wb_rf_wen(debug_wb_rf_wen), .debug_wb_rf_wnum(debug_wb_rf_wnum),
        .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (error_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic load_testdata();
        int pos;
        $readmemh("tests/core_testdata.hex", testdata);
        prog_len = int'(testdata[0]);
        for (int n = 0; n < prog_len; n++) begin
            prog[n] = testdata[1 + n];
        end
        pos = 1 + prog_len;
        trace_len = int'(testdata[pos]);
        pos++;
        for (int n = 0; n < trace_len; n++) begin
            exp_pc[n]   = testdata[pos];
            exp_reg[n]  = testdata[pos + 1];
            exp_data[n] = testdata[pos + 2];
            pos += 3;
        end
        store_len = int'(testdata[pos]);
        pos++;
        for (int n = 0; n < store_len; n++) begin
            exp_addr[n]  = testdata[pos];
            exp_store[n] = testdata[pos + 1];
            pos += 2;
        end
    endtask

    // nop outside the loaded program
    function automatic word_t fetch_word(input word_t adr);
        word_t idx;
        idx = (adr - reset_pc) >> 2;
        if (idx < word_t'(prog_len)) begin
            return prog[idx[5:0]];
        end
        return '0;
    endfunction

    ////////////////////////////////////////////////////////////
    // wishbone slaves with 0 to 3 wait cycles each
    ////////////////////////////////////////////////////////////
    task automatic serve_fetch();
        if (reset) begin
            i_rsp     = '0;
            i_started = 1'b0;
        end else if (i_rsp.ack) begin
            i_rsp.ack = 1'b0;
        end else if (i_req.cyc && i_req.stb) begin
            if (!i_started) begin
                i_started = 1'b1;
                i_wait    = int'($urandom % 4);
            end
            if (i_wait == 0) begin
                check_value("fetch_we", 32'h0, {31'b0, i_req.we});
                check_value("fetch_sel", 32'h0000_000f, {28'b0, i_req.sel});
                i_rsp.ack = 1'b1;
                i_rsp.dat = fetch_word(i_req.adr);
                i_started = 1'b0;
            end else begin
                i_wait--;
            end
        end
    endtask

    task automatic record_store();
        string name;
        int    errs_before;
        if (store_seen < store_len) begin
            errs_before = error_count;
            name = $sformatf("store_%0d", store_seen);
            check_value({name, "_addr"}, exp_addr[store_seen], d_req.adr);
            check_value({name, "_data"}, exp_store[store_seen], d_req.dat);
            check_value({name, "_sel"}, 32'h0000_000f, {28'b0, d_req.sel});
            finish_test(name, errs_before);
        end else begin
            $display("unexpected store to %h beyond the %0d expected", d_req.adr, store_len);
            error_count++;
        end
        store_seen++;
    endtask

    task automatic serve_data();
        if (reset) begin
            d_rsp     = '0;
            d_started = 1'b0;
        end else if (d_rsp.ack) begin
            d_rsp.ack = 1'b0;
        end else if (d_req.cyc && d_req.stb) begin
            if (!d_started) begin
                d_started = 1'b1;
                d_wait    = int'($urandom % 4);
            end
            if (d_wait == 0) begin
                d_rsp.ack = 1'b1;
                d_started = 1'b0;
                if (d_req.we) begin
                    dmem[d_req.adr[7:2]] = d_req.dat;
                    record_store();
                end else begin
                    d_rsp.dat = dmem[d_req.adr[7:2]];
                end
            end else begin
                d_wait--;
            end
        end
    endtask

    task automatic watch_first_fetch();
        if (!reset && !fetch_seen) begin
            if (i_req.cyc) begin
                fetch_seen = 1'b1;
                first_adr  = i_req.adr;
            end
            if (d_req.cyc || d_req.stb || debug_wb_rf_wen != 4'h0) begin
                early_activity = 1'b1;
            end
        end
    endtask

    task automatic watch_trace();
        string name;
        int    errs_before;
        if (!reset && debug_wb_rf_wen != 4'h0) begin
            if (trace_seen < trace_len) begin
                errs_before = error_count;
                name = $sformatf("trace_%0d", trace_seen);
                check_value({name, "_pc"}, exp_pc[trace_seen], debug_wb_pc);
                check_value({name, "_reg"}, exp_reg[trace_seen], {27'b0, debug_wb_rf_wnum});
                check_value({name, "_data"}, exp_data[trace_seen], debug_wb_rf_wdata);
                check_value({name, "_wen"}, 32'h0000_000f, {28'b0, debug_wb_rf_wen});
                finish_test(name, errs_before);
            end else begin
                $display("unexpected trace entry at pc %h beyond the %0d expected",
                         debug_wb_pc, trace_len);
                error_count++;
            end
            trace_seen++;
        end
    endtask

    // slaves and monitors share one process that owns the random sequence
    initial begin
        void'($urandom(19));
        forever begin
            @(negedge clk);
            serve_fetch();
            serve_data();
            watch_first_fetch();
            watch_trace();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: program did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int errs_before;
        i_rsp          = '0;
        d_rsp          = '0;
        i_started      = 1'b0;
        d_started      = 1'b0;
        i_wait         = 0;
        d_wait         = 0;
        trace_seen     = 0;
        store_seen     = 0;
        error_count    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        cycle_count    = 0;
        fetch_seen     = 1'b0;
        early_activity = 1'b0;
        first_adr      = '0;
        for (int n = 0; n < 64; n++) begin
            dmem[n] = '0;
        end
        load_testdata();
        // twice the worst case of 5 cycles per instruction
        cycle_limit = (prog_len + 20) * 5 * 2;

        // buses and trace idle while reset is held
        repeat (2) @(posedge clk);
        @(negedge clk);
        errs_before = error_count;
        check_value("reset_i_cyc", 32'h0, {31'b0, i_req.cyc});
        check_value("reset_i_stb", 32'h0, {31'b0, i_req.stb});
        check_value("reset_d_cyc", 32'h0, {31'b0, d_req.cyc});
        check_value("reset_d_stb", 32'h0, {31'b0, d_req.stb});
        check_value("reset_trace_wen", 32'h0, {28'b0, debug_wb_rf_wen});
        finish_test("reset_state", errs_before);

        wait (fetch_seen);
        errs_before = error_count;
        check_value("first_fetch_adr", reset_pc, first_adr);
        check_value("first_fetch_quiet", 32'h0, {31'b0, early_activity});
        finish_test("first_fetch", errs_before);

        wait (trace_seen >= trace_len && store_seen >= store_len);
        // drain so that a repeated instruction would still show up
        repeat (20) @(posedge clk);
        @(negedge clk);
        errs_before = error_count;
        check_value("trace_count", word_t'(trace_len), word_t'(trace_seen));
        check_value("store_count", word_t'(store_len), word_t'(store_seen));
        finish_test("entry_counts", errs_before);

        $display("tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
